// File: hw/armPkg.sv
package armPkg;

  // ==================================================
  // Instruction field constants
  // ==================================================

  // Width of a register index in the instruction word
  localparam int regIndexWidth = 4;

  // Condition field value for "always"
  // Every other condition runs as a no-op
  localparam logic [3:0] condAlways = 4'b1110;

  // Instruction class in bits 27:26
  localparam logic [1:0] opClassDp  = 2'b00;
  localparam logic [1:0] opClassMem = 2'b01;

  // Register index of the PC, never written by this core
  localparam logic [regIndexWidth-1:0] pcIndex = 4'd15;

  // ==================================================
  // Enumerations
  // ==================================================

  // Data-processing opcodes, values are the ARM encodings
  typedef enum logic [3:0] {
    aluAnd = 4'b0000,
    aluEor = 4'b0001,
    aluSub = 4'b0010,
    aluRsb = 4'b0011,
    aluAdd = 4'b0100,
    aluOrr = 4'b1100,
    aluMov = 4'b1101,
    aluBic = 4'b1110,
    aluMvn = 4'b1111
  } aluOp_t;

  // Shift types as encoded in bits 6:5
  typedef enum logic [1:0] {
    shiftLsl = 2'b00,
    shiftLsr = 2'b01,
    shiftAsr = 2'b10,
    shiftRor = 2'b11
  } shiftType_t;

endpackage

// File: hw/alu.sv
`timescale 1ns/1ns

module alu import armPkg::*; (
  input  logic [31:0] SrcA,
  input  logic [31:0] SrcB,
  input  aluOp_t      ALUControl,
  output logic [31:0] ALUResult
);

  // No flags, results only
  always_comb begin
    case (ALUControl)
      aluAnd:  ALUResult = SrcA & SrcB;
      aluEor:  ALUResult = SrcA ^ SrcB;
      aluSub:  ALUResult = SrcA - SrcB;
      // Reverse subtract
      aluRsb:  ALUResult = SrcB - SrcA;
      aluAdd:  ALUResult = SrcA + SrcB;
      aluOrr:  ALUResult = SrcA | SrcB;
      // Operand 2 straight through
      aluMov:  ALUResult = SrcB;
      // Clear the bits set in operand 2
      aluBic:  ALUResult = SrcA & ~SrcB;
      aluMvn:  ALUResult = ~SrcB;
      default: ALUResult = '0;
    endcase
  end

endmodule

// File: hw/barrelShifter.sv
`timescale 1ns/1ns

module barrelShifter import armPkg::*; (
  input  logic [31:0] shiftIn,
  input  shiftType_t  ShiftType,
  input  logic [4:0]  ShiftAmt,
  output logic [31:0] shiftOut
);

  // Doubled word so a right shift yields the rotate
  logic [63:0] doubled;
  logic [63:0] rotated;

  assign doubled = {shiftIn, shiftIn};
  assign rotated = doubled >> ShiftAmt;

  // Amount zero falls through unchanged for every type
  always_comb begin
    case (ShiftType)
      shiftLsl: shiftOut = shiftIn << ShiftAmt;
      shiftLsr: shiftOut = shiftIn >> ShiftAmt;
      // Sign bit fills from the left
      shiftAsr: shiftOut = $signed(shiftIn) >>> ShiftAmt;
      shiftRor: shiftOut = rotated[31:0];
      default:  shiftOut = shiftIn;
    endcase
  end

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ns

module regFile import armPkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [regIndexWidth-1:0] RA1,
  input  logic [regIndexWidth-1:0] RA2,
  input  logic [regIndexWidth-1:0] WA3,
  input  logic [31:0]              WD3,
  input  logic                     WE3,
  output logic [31:0]              RD1,
  output logic [31:0]              RD2
);

  // r0 to r14, no storage for the PC
  logic [31:0] regs [0:14];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 15; i++)
        regs[i] <= '0;
    end else if (WE3 && WA3 != pcIndex) begin
      regs[WA3] <= WD3;
    end
  end

  // Same-cycle write shows on the read port
  function automatic logic [31:0] readReg(input logic [regIndexWidth-1:0] ra);
    if (ra == pcIndex)
      return '0;
    else if (WE3 && WA3 == ra)
      return WD3;
    else
      return regs[ra];
  endfunction

  assign RD1 = readReg(RA1);
  assign RD2 = readReg(RA2);

endmodule

// File: hw/controller.sv
`timescale 1ns/1ns

module controller import armPkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [31:0]              InstrD,
  // Decode
  output logic                     ImmSrcD,
  output logic [regIndexWidth-1:0] RA1D,
  output logic [regIndexWidth-1:0] RA2D,
  // Execute
  output logic                     ALUSrcE,
  output aluOp_t                   ALUControlE,
  output shiftType_t               ShiftTypeE,
  output logic [4:0]               ShiftAmtE,
  output logic [1:0]               ForwardAE,
  output logic [1:0]               ForwardBE,
  // Memory
  output logic                     MemWriteM,
  // Writeback
  output logic                     RegWriteW,
  output logic                     MemtoRegW,
  output logic [regIndexWidth-1:0] WA3W,
  // Hazard
  output logic                     StallF,
  output logic                     StallD,
  output logic                     FlushE
);

  logic isDpD, isMemD, isLoadD, isStoreD, movLikeD;
  logic useAD, useBD, regWriteD, aluSrcD;
  aluOp_t aluControlD;
  shiftType_t shiftTypeD;
  logic [4:0] shiftAmtD;
  logic regWriteE, memWriteE, memtoRegE;
  logic [regIndexWidth-1:0] wa3E, ra1E, ra2E;
  logic regWriteM, memtoRegM;
  logic [regIndexWidth-1:0] wa3M;
  logic loadUse;

  // ==================================================
  // Decode
  // ==================================================

  // Data-processing with immediate or immediate-shifted register
  // Bit 4 set means register-shifted register or multiply, not supported
  always_comb begin
    isDpD = 1'b0;
    if (InstrD[31:28] == condAlways && InstrD[27:26] == opClassDp &&
        (InstrD[25] || !InstrD[4])) begin
      case (InstrD[24:21])
        aluAnd, aluEor, aluSub, aluRsb, aluAdd,
        aluOrr, aluMov, aluBic, aluMvn: isDpD = 1'b1;
        default:                        isDpD = 1'b0;
      endcase
    end
  end

  // Word LDR/STR, pre-indexed, positive immediate offset, no writeback
  assign isMemD   = InstrD[31:28] == condAlways && InstrD[27:26] == opClassMem &&
                    InstrD[25:21] == 5'b01100;
  assign isLoadD  = isMemD && InstrD[20];
  assign isStoreD = isMemD && !InstrD[20];

  // MOV and MVN ignore Rn
  assign movLikeD = InstrD[24:21] == aluMov || InstrD[24:21] == aluMvn;
  assign useAD    = isMemD || (isDpD && !movLikeD);
  // Store data comes through port 2 as Rd
  assign useBD    = isStoreD || (isDpD && !InstrD[25]);

  assign RA1D = InstrD[19:16];
  assign RA2D = isStoreD ? InstrD[15:12] : InstrD[3:0];

  // Writes to r15 are dropped
  assign regWriteD = (isDpD || isLoadD) && InstrD[15:12] != pcIndex;
  assign ImmSrcD   = isMemD;
  assign aluSrcD   = isMemD || (isDpD && InstrD[25]);
  // Memory access computes base plus offset
  assign aluControlD = isDpD ? aluOp_t'(InstrD[24:21]) : aluAdd;

  // Operand 2 shift setup
  always_comb begin
    shiftTypeD = shiftLsl;
    shiftAmtD  = 5'd0;
    if (isDpD && InstrD[25]) begin
      // Rotated immediate, ROR by twice the rotate field
      shiftTypeD = shiftRor;
      shiftAmtD  = {InstrD[11:8], 1'b0};
    end else if (isDpD) begin
      shiftTypeD = shiftType_t'(InstrD[6:5]);
      shiftAmtD  = InstrD[11:7];
    end
  end

  // ==================================================
  // Pipeline control registers
  // ==================================================

  // Execute, bubble on load-use flush
  always_ff @(posedge clk) begin
    if (reset || FlushE) begin
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      memtoRegE   <= 1'b0;
      wa3E        <= '0;
      ra1E        <= '0;
      ra2E        <= '0;
      ALUSrcE     <= 1'b0;
      ALUControlE <= aluAdd;
      ShiftTypeE  <= shiftLsl;
      ShiftAmtE   <= 5'd0;
    end else begin
      regWriteE   <= regWriteD;
      memWriteE   <= isStoreD;
      memtoRegE   <= isLoadD;
      wa3E        <= InstrD[15:12];
      ra1E        <= RA1D;
      ra2E        <= RA2D;
      ALUSrcE     <= aluSrcD;
      ALUControlE <= aluControlD;
      ShiftTypeE  <= shiftTypeD;
      ShiftAmtE   <= shiftAmtD;
    end
  end

  // Memory and writeback
  always_ff @(posedge clk) begin
    if (reset) begin
      regWriteM <= 1'b0;
      MemWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      wa3M      <= '0;
      RegWriteW <= 1'b0;
      MemtoRegW <= 1'b0;
      WA3W      <= '0;
    end else begin
      regWriteM <= regWriteE;
      MemWriteM <= memWriteE;
      memtoRegM <= memtoRegE;
      wa3M      <= wa3E;
      RegWriteW <= regWriteM;
      MemtoRegW <= memtoRegM;
      WA3W      <= wa3M;
    end
  end

  // ==================================================
  // Hazards
  // ==================================================

  // Memory stage wins over writeback
  function automatic logic [1:0] forwardSel(input logic [regIndexWidth-1:0] ra);
    if (regWriteM && wa3M == ra)
      return 2'b10;
    else if (RegWriteW && WA3W == ra)
      return 2'b01;
    else
      return 2'b00;
  endfunction

  assign ForwardAE = forwardSel(ra1E);
  assign ForwardBE = forwardSel(ra2E);

  // Load in execute feeding the instruction in decode
  assign loadUse = memtoRegE && regWriteE &&
                   ((useAD && RA1D == wa3E) || (useBD && RA2D == wa3E));

  assign StallF = loadUse;
  assign StallD = loadUse;
  assign FlushE = loadUse;

endmodule

// File: hw/datapath.sv
`timescale 1ns/1ns

module datapath import armPkg::*; #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  logic                     clk,
  input  logic                     reset,
  // Fetch
  output logic [31:0]              PCF,
  input  logic [31:0]              InstrF,
  // Decode
  output logic [31:0]              InstrD,
  input  logic                     ImmSrcD,
  input  logic [regIndexWidth-1:0] RA1D,
  input  logic [regIndexWidth-1:0] RA2D,
  // Execute
  input  logic                     ALUSrcE,
  input  aluOp_t                   ALUControlE,
  input  shiftType_t               ShiftTypeE,
  input  logic [4:0]               ShiftAmtE,
  input  logic [1:0]               ForwardAE,
  input  logic [1:0]               ForwardBE,
  // Memory
  output logic [31:0]              ALUOutM,
  output logic [31:0]              WriteDataM,
  input  logic [31:0]              ReadDataM,
  // Writeback
  input  logic                     RegWriteW,
  input  logic                     MemtoRegW,
  input  logic [regIndexWidth-1:0] WA3W,
  output logic [31:0]              ResultW,
  // Hazard
  input  logic                     StallF,
  input  logic                     StallD,
  input  logic                     FlushE
);

  logic [31:0] pcPlus4F;
  logic [31:0] rd1D, rd2D, extImmD;
  logic [31:0] rd1E, rd2E, extImmE;
  logic [31:0] srcAE, writeDataE, shiftInE, srcBE, aluResultE;
  logic [31:0] aluOutW, readDataW;

  // ==================================================
  // Fetch
  // ==================================================

  assign pcPlus4F = PCF + 32'd4;

  // PC holds during a load-use stall
  always_ff @(posedge clk) begin
    if (reset)
      PCF <= resetPc;
    else if (!StallF)
      PCF <= pcPlus4F;
  end

  // ==================================================
  // Decode
  // ==================================================

  // Zero word decodes as a no-op (condition field 0000)
  always_ff @(posedge clk) begin
    if (reset)
      InstrD <= '0;
    else if (!StallD)
      InstrD <= InstrF;
  end

  regFile u_regFile (
    .clk  (clk),
    .reset(reset),
    .RA1  (RA1D),
    .RA2  (RA2D),
    .WA3  (WA3W),
    .WD3  (ResultW),
    .WE3  (RegWriteW),
    .RD1  (rd1D),
    .RD2  (rd2D)
  );

  // 12-bit memory offset or 8-bit immediate rotated later in the shifter
  assign extImmD = ImmSrcD ? {20'd0, InstrD[11:0]} : {24'd0, InstrD[7:0]};

  // ==================================================
  // Execute
  // ==================================================

  // Bubble carries zero operands
  always_ff @(posedge clk) begin
    if (FlushE) begin
      rd1E    <= '0;
      rd2E    <= '0;
      extImmE <= '0;
    end else begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      extImmE <= extImmD;
    end
  end

  // Forward select, 10 from memory, 01 from writeback
  always_comb begin
    case (ForwardAE)
      2'b10:   srcAE = ALUOutM;
      2'b01:   srcAE = ResultW;
      default: srcAE = rd1E;
    endcase
    case (ForwardBE)
      2'b10:   writeDataE = ALUOutM;
      2'b01:   writeDataE = ResultW;
      default: writeDataE = rd2E;
    endcase
  end

  // Immediate or register goes through the shifter as operand 2
  assign shiftInE = ALUSrcE ? extImmE : writeDataE;

  barrelShifter u_barrelShifter (
    .shiftIn  (shiftInE),
    .ShiftType(ShiftTypeE),
    .ShiftAmt (ShiftAmtE),
    .shiftOut (srcBE)
  );

  alu u_alu (
    .SrcA      (srcAE),
    .SrcB      (srcBE),
    .ALUControl(ALUControlE),
    .ALUResult (aluResultE)
  );

  // ==================================================
  // Memory and writeback
  // ==================================================

  always_ff @(posedge clk) begin
    ALUOutM    <= aluResultE;
    WriteDataM <= writeDataE;
    aluOutW    <= ALUOutM;
    readDataW  <= ReadDataM;
  end

  assign ResultW = MemtoRegW ? readDataW : aluOutW;

endmodule

// File: hw/armCore.sv
`timescale 1ns/1ns

module armCore import armPkg::*; #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  logic                     clk,
  input  logic                     reset,
  // Instruction memory
  output logic [31:0]              PCF,
  input  logic [31:0]              InstrF,
  // Data memory
  output logic [31:0]              ALUOutM,
  output logic [31:0]              WriteDataM,
  output logic                     MemWriteM,
  input  logic [31:0]              ReadDataM,
  // Retire trace
  output logic                     RegWriteW,
  output logic [regIndexWidth-1:0] WA3W,
  output logic [31:0]              ResultW
);

  // Decode stage
  logic [31:0]              InstrD;
  logic                     ImmSrcD;
  logic [regIndexWidth-1:0] RA1D, RA2D;

  // Execute stage
  logic                     ALUSrcE;
  aluOp_t                   ALUControlE;
  shiftType_t               ShiftTypeE;
  logic [4:0]               ShiftAmtE;
  logic [1:0]               ForwardAE, ForwardBE;

  // Writeback and hazard
  logic                     MemtoRegW;
  logic                     StallF, StallD, FlushE;

  // Decode, hazard detection and per-stage control bits
  controller u_controller (
    .clk        (clk),
    .reset      (reset),
    .InstrD     (InstrD),
    .ImmSrcD    (ImmSrcD),
    .RA1D       (RA1D),
    .RA2D       (RA2D),
    .ALUSrcE    (ALUSrcE),
    .ALUControlE(ALUControlE),
    .ShiftTypeE (ShiftTypeE),
    .ShiftAmtE  (ShiftAmtE),
    .ForwardAE  (ForwardAE),
    .ForwardBE  (ForwardBE),
    .MemWriteM  (MemWriteM),
    .RegWriteW  (RegWriteW),
    .MemtoRegW  (MemtoRegW),
    .WA3W       (WA3W),
    .StallF     (StallF),
    .StallD     (StallD),
    .FlushE     (FlushE)
  );

  // PC, pipeline registers, register file, shifter and ALU
  datapath #(
    .resetPc(resetPc)
  ) u_datapath (
    .clk        (clk),
    .reset      (reset),
    .PCF        (PCF),
    .InstrF     (InstrF),
    .InstrD     (InstrD),
    .ImmSrcD    (ImmSrcD),
    .RA1D       (RA1D),
    .RA2D       (RA2D),
    .ALUSrcE    (ALUSrcE),
    .ALUControlE(ALUControlE),
    .ShiftTypeE (ShiftTypeE),
    .ShiftAmtE  (ShiftAmtE),
    .ForwardAE  (ForwardAE),
    .ForwardBE  (ForwardBE),
    .ALUOutM    (ALUOutM),
    .WriteDataM (WriteDataM),
    .ReadDataM  (ReadDataM),
    .RegWriteW  (RegWriteW),
    .MemtoRegW  (MemtoRegW),
    .WA3W       (WA3W),
    .ResultW    (ResultW),
    .StallF     (StallF),
    .StallD     (StallD),
    .FlushE     (FlushE)
  );

endmodule

// File: bench/armCore_properties.sv
`timescale 1ns/1ns

module armCore_properties (
  input logic clk,
  input logic reset,
  input logic StallF,
  input logic StallD,
  input logic FlushE,
  input logic RegWriteW,
  input logic MemWriteM
);

  // Failed assertion count
  int failureCount = 0;

  // Fetch and decode hold together on load-use
  stallTogether: assert property (@(posedge clk) disable iff (reset) StallF == StallD)
    else begin
      failureCount++;
      $error("StallF and StallD differ");
    end

  // Bubble in execute only while decode holds
  flushWithStall: assert property (@(posedge clk) disable iff (reset) FlushE |-> StallD)
    else begin
      failureCount++;
      $error("FlushE high without StallD");
    end

  // A load-use hazard costs exactly one cycle
  stallOneCycle: assert property (@(posedge clk) disable iff (reset) StallD |=> !StallD)
    else begin
      failureCount++;
      $error("StallD held for more than one cycle");
    end

  // The bubble reaches memory and writeback with no store and no write
  bubbleIdle: assert property (@(posedge clk) disable iff (reset)
                               FlushE |-> ##2 !MemWriteM ##1 !RegWriteW)
    else begin
      failureCount++;
      $error("Flushed bubble produced a store or a register write");
    end

  // Reset clears the write enables one cycle later
  resetClears: assert property (@(posedge clk) reset |=> (!RegWriteW && !MemWriteM))
    else begin
      failureCount++;
      $error("RegWriteW or MemWriteM high after reset");
    end

endmodule

// File: bench/armCoreTb.sv
`timescale 1ns/1ns

module armCoreTb import armPkg::*; ();

  localparam logic [31:0] progBase = 32'h0000_0100;
  localparam int numInstr = 200;
  localparam int watchdogCycles = 2 * numInstr + 50;

  logic        clk;
  logic        reset;
  logic [31:0] PCF, InstrF;
  logic [31:0] ALUOutM, WriteDataM, ReadDataM;
  logic        MemWriteM;
  logic        RegWriteW;
  logic [3:0]  WA3W;
  logic [31:0] ResultW;

  // Program ROM and data memory on the core's ports
  logic [31:0] rom [0:numInstr-1];
  logic [31:0] dmem [0:63];
  logic [31:0] romIndex;

  // Sequential model state
  logic [31:0] modelRegs [0:7];
  logic [31:0] modelMem [0:63];
  logic [31:0] lfsr;

  // Expected register writes and stores, oldest first
  logic [3:0]  expWa[$];
  logic [31:0] expWd[$];
  logic [5:0]  expSi[$];
  logic [31:0] expSd[$];

  int errorCount = 0;
  int writeCount = 0;
  int storeCount = 0;
  int cycle = 0;
  int assertFails;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  armCore #(
    .resetPc(progBase)
  ) u_dut (
    .clk       (clk),
    .reset     (reset),
    .PCF       (PCF),
    .InstrF    (InstrF),
    .ALUOutM   (ALUOutM),
    .WriteDataM(WriteDataM),
    .MemWriteM (MemWriteM),
    .ReadDataM (ReadDataM),
    .RegWriteW (RegWriteW),
    .WA3W      (WA3W),
    .ResultW   (ResultW)
  );

  bind controller armCore_properties u_properties (.*);

  // ==================================================
  // Memories
  // ==================================================

  // Past the program the ROM returns the no-op word 0
  assign romIndex = (PCF - progBase) >> 2;
  assign InstrF   = (romIndex < numInstr) ? rom[romIndex[7:0]] : 32'd0;
  assign ReadDataM = dmem[ALUOutM[7:2]];

  // Initial data word mixing every address bit
  function automatic logic [31:0] memFill(input logic [5:0] idx);
    return 32'h5a00_0000 | ({26'd0, idx} * 32'h0004_1083);
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      for (int j = 0; j < 64; j++)
        dmem[6'(j)] <= memFill(6'(j));
    end else if (MemWriteM) begin
      dmem[ALUOutM[7:2]] <= WriteDataM;
    end
  end

  // ==================================================
  // Random program and reference model
  // ==================================================

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] takeRandomBits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr     = {lfsr[30:0], feedback};
      value    = {value[30:0], feedback};
    end
    return value;
  endfunction

  // Maps 4 random bits onto the nine opcodes
  function automatic logic [3:0] opcodeFor(input logic [3:0] pick);
    case (pick)
      4'd0, 4'd9:  return aluAnd;
      4'd1, 4'd10: return aluEor;
      4'd2, 4'd11: return aluSub;
      4'd3, 4'd12: return aluRsb;
      4'd4, 4'd13: return aluAdd;
      4'd5, 4'd14: return aluOrr;
      4'd6, 4'd15: return aluMov;
      4'd7:        return aluBic;
      default:     return aluMvn;
    endcase
  endfunction

  function automatic logic [31:0] rotateRight(input logic [31:0] x, input logic [4:0] amt);
    logic [5:0] back;
    back = 6'd32 - {1'b0, amt};
    if (amt == 5'd0)
      return x;
    else
      return (x >> amt) | (x << back);
  endfunction

  // Shift by immediate where amount zero leaves the value alone
  function automatic logic [31:0] shiftOperand(input logic [31:0] x, input logic [1:0] kind,
                                               input logic [4:0] amt);
    case (kind)
      2'b00:   return x << amt;
      2'b01:   return x >> amt;
      2'b10:   return $signed(x) >>> amt;
      default: return rotateRight(x, amt);
    endcase
  endfunction

  function automatic logic [31:0] dataOp(input logic [3:0] op, input logic [31:0] a,
                                         input logic [31:0] b);
    case (op)
      aluAnd:  return a & b;
      aluEor:  return a ^ b;
      aluSub:  return a - b;
      aluRsb:  return b - a;
      aluAdd:  return a + b;
      aluOrr:  return a | b;
      aluMov:  return b;
      aluBic:  return a & ~b;
      default: return ~b;
    endcase
  endfunction

  // Fills the ROM and runs each instruction through the model in order
  task automatic buildProgram();
    logic [31:0] r, instr, opnd2, addr, value;
    logic [3:0]  cond, op;
    logic [2:0]  rd, rn, rm, kind;
    logic [11:0] field;
    logic        immForm;
    for (int k = 0; k < 8; k++)
      modelRegs[3'(k)] = '0;
    for (int j = 0; j < 64; j++)
      modelMem[6'(j)] = memFill(6'(j));
    for (int i = 0; i < numInstr; i++) begin
      // About one in sixteen gets a never-taken condition
      r    = takeRandomBits(7);
      cond = (r[6:3] == 4'd0) ? {1'b0, r[2:0]} : condAlways;
      r    = takeRandomBits(9);
      rd   = r[2:0];
      rn   = r[5:3];
      kind = r[8:6];
      if (kind < 3'd2) begin
        // LDR for kind 0 and STR for kind 1
        r     = takeRandomBits(12);
        instr = {cond, 2'b01, 5'b01100, ~kind[0], 1'b0, rn, 1'b0, rd, r[11:0]};
        addr  = modelRegs[rn] + {20'd0, r[11:0]};
        if (cond == condAlways && kind == 3'd0) begin
          value = modelMem[addr[7:2]];
          modelRegs[rd] = value;
          expWa.push_back({1'b0, rd});
          expWd.push_back(value);
        end else if (cond == condAlways) begin
          modelMem[addr[7:2]] = modelRegs[rd];
          expSi.push_back(addr[7:2]);
          expSd.push_back(modelRegs[rd]);
        end
      end else begin
        r       = takeRandomBits(17);
        op      = opcodeFor(r[3:0]);
        immForm = r[4];
        rm      = r[7:5];
        if (immForm) begin
          field = r[16:5];
          opnd2 = rotateRight({24'd0, field[7:0]}, {field[11:8], 1'b0});
        end else begin
          // Shift amount zero about a quarter of the time
          field = {(r[16:15] == 2'b00) ? 5'd0 : r[14:10], r[9:8], 2'b00, rm};
          opnd2 = shiftOperand(modelRegs[rm], field[6:5], field[11:7]);
        end
        instr = {cond, 2'b00, immForm, op, 1'b0, 1'b0, rn, 1'b0, rd, field};
        if (cond == condAlways) begin
          value = dataOp(op, modelRegs[rn], opnd2);
          modelRegs[rd] = value;
          expWa.push_back({1'b0, rd});
          expWd.push_back(value);
        end
      end
      rom[8'(i)] = instr;
    end
  endtask

  // ==================================================
  // Checking
  // ==================================================

  task automatic checkWrite();
    logic [3:0]  wa;
    logic [31:0] wd;
    writeCount++;
    if (expWa.size() == 0) begin
      $display("Register write to r%0d at %0t after the last expected write", WA3W, $time);
      errorCount++;
    end else begin
      wa = expWa.pop_front();
      wd = expWd.pop_front();
      if (WA3W !== wa) begin
        $display("** Error at %0t: WA3W = %0d, expected %0d", $time, WA3W, wa);
        errorCount++;
      end
      if (ResultW !== wd) begin
        $display("** Error at %0t: ResultW = %h, expected %h", $time, ResultW, wd);
        errorCount++;
      end
    end
  endtask

  task automatic checkStore();
    logic [5:0]  si;
    logic [31:0] sd;
    storeCount++;
    if (expSi.size() == 0) begin
      $display("Store to word %0d at %0t after the last expected store", ALUOutM[7:2], $time);
      errorCount++;
    end else begin
      si = expSi.pop_front();
      sd = expSd.pop_front();
      if (ALUOutM[7:2] !== si) begin
        $display("** Error at %0t: ALUOutM[7:2] = %0d, expected %0d", $time, ALUOutM[7:2], si);
        errorCount++;
      end
      if (WriteDataM !== sd) begin
        $display("** Error at %0t: WriteDataM = %h, expected %h", $time, WriteDataM, sd);
        errorCount++;
      end
    end
  endtask

  // Outputs sampled mid-cycle with cycles counted from reset release
  always @(negedge clk) begin
    if (reset) begin
      cycle = 0;
    end else begin
      if (cycle == 0 && PCF !== progBase) begin
        $display("** Error at %0t: PCF = %h, expected %h", $time, PCF, progBase);
        errorCount++;
      end
      if (cycle < 3 && (RegWriteW !== 1'b0 || MemWriteM !== 1'b0)) begin
        $display("Write or store at %0t before any instruction could retire", $time);
        errorCount++;
      end else begin
        if (RegWriteW)
          checkWrite();
        if (MemWriteM)
          checkStore();
      end
      cycle++;
    end
  end

  initial begin
    lfsr  = 32'he032;
    reset = 1'b1;
    buildProgram();
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    // Run until every event is seen and the whole program has drained
    while (expWa.size() != 0 || expSi.size() != 0 || PCF < progBase + 32'(4 * numInstr))
      @(negedge clk);
    repeat (8) @(negedge clk);
    assertFails = u_dut.u_controller.u_properties.failureCount;
    $display("Writes checked %0d, stores checked %0d, errors %0d, assertion failures %0d",
             writeCount, storeCount, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, %0d writes and %0d stores never appeared",
             watchdogCycles, expWa.size(), expSi.size());
    $display("sim failed");
    $finish;
  end

endmodule

// File: flist.f
hw/armPkg.sv
hw/alu.sv
hw/barrelShifter.sv
hw/regFile.sv
hw/controller.sv
hw/datapath.sv
hw/armCore.sv
bench/armCore_properties.sv
bench/armCoreTb.sv

// File: run.sh
#!/bin/sh
# Build the core and its bench with Verilator, run, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module armCoreTb \
  -f flist.f -Mdir obj_dir -o armCoreSim &&
./obj_dir/armCoreSim +verilator+error+limit+100 2>&1 |
  awk '{ print } /^sim passed$/ { ok = 1 } END { exit !ok }' &&
echo "run.sh: PASS" ||
{ echo "run.sh: FAIL"; exit 1; }
